/* hazPkg.sv */
package hazPkg;

    // Datapath and register file sizes
    localparam int WordBits  = 16;
    localparam int RegBits   = 3;
    localparam int OpBits    = 5;
    localparam int FieldBits = 5;
    localparam int ClassBits = 3;

    // Older instructions tracked behind fetch
    localparam int NumStages = 4;

    // Slot positions in the stage chain
    localparam int SlotId  = 0;
    localparam int SlotEx  = 1;
    localparam int SlotMem = 2;
    localparam int SlotWb  = 3;

    // Forwarding controls, one bit per path
    localparam int FwdWidth = 6;

    // Control and flow opcodes
    localparam logic [OpBits-1:0] OpHalt = 5'b00000;
    localparam logic [OpBits-1:0] OpNop  = 5'b00001;
    localparam logic [OpBits-1:0] OpJ    = 5'b00100;
    localparam logic [OpBits-1:0] OpJal  = 5'b00110;
    localparam logic [OpBits-1:0] OpJr   = 5'b00111;

    // Top opcode bits shared by all jumps and all branches
    localparam logic [ClassBits-1:0] JumpClass   = 3'b001;
    localparam logic [ClassBits-1:0] BranchClass = 3'b011;

    // R-format ALU opcodes, both read rs and rt
    localparam logic [OpBits-1:0] OpAddR   = 5'b11011;
    localparam logic [OpBits-1:0] OpLogicR = 5'b11010;

    // Stores read the data register from the rt field
    localparam logic [OpBits-1:0] OpStore    = 5'b10000;
    localparam logic [OpBits-1:0] OpStoreUpd = 5'b10011;

    // Register format: two sources and a function code
    typedef struct packed {
        logic [OpBits-1:0]    opcode;
        logic [RegBits-1:0]   rs;
        logic [RegBits-1:0]   rt;
        logic [FieldBits-1:0] funct;
    } regFields;

    // Immediate format: bits 7:5 are a destination, never a source
    typedef struct packed {
        logic [OpBits-1:0]    opcode;
        logic [RegBits-1:0]   rs;
        logic [RegBits-1:0]   rd;
        logic [FieldBits-1:0] imm5;
    } immFields;

    // Same instruction word seen through either format
    typedef union packed {
        regFields r;
        immFields i;
    } instrWord;

endpackage

/* instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  hazPkg::instrWord                instr,
    input  logic [hazPkg::RegBits-1:0]      rd,
    input  logic                            regWrite,
    input  logic                            memEnable,
    input  logic [hazPkg::WordBits-1:0]     reg1Data,
    input  logic [hazPkg::WordBits-1:0]     imm,
    input  logic                            nop,
    output logic [hazPkg::RegBits-1:0]      rsIdx,
    output logic [hazPkg::RegBits-1:0]      rtIdx,
    output logic                            rsUsed,
    output logic                            rtUsed,
    output logic                            isJr,
    output logic                            isJumpBranch,
    output logic                            isNop,
    output logic [hazPkg::WordBits-1:0]     memAddr,
    output logic [hazPkg::RegBits-1:0]      entryRd,
    output logic                            entryRegWrite,
    output logic                            entryMemEnable,
    output logic [hazPkg::WordBits-1:0]     entryMemAddr
);
    import hazPkg::*;

    logic [OpBits-1:0]    opcode;
    logic [ClassBits-1:0] opClass;

    // Opcode sits in the same place in both views
    assign opcode  = instr.r.opcode;
    assign opClass = opcode[OpBits-1 -: ClassBits];

    assign isNop        = (opcode == OpNop);
    assign isJr         = (opcode == OpJr);
    assign isJumpBranch = (opClass == JumpClass) || (opClass == BranchClass);

    // Which source fields this opcode actually reads
    always_comb begin
        rsUsed = 1'b1;
        rtUsed = 1'b0;
        case (opcode)
            OpAddR, OpLogicR, OpStore, OpStoreUpd: begin
                rtUsed = 1'b1;
            end
            OpNop, OpHalt, OpJ, OpJal: begin
                rsUsed = 1'b0;
            end
            default: begin
                rsUsed = 1'b1;
            end
        endcase
    end

    // rs sits in the same place in both views
    assign rsIdx = instr.r.rs;

    // rt only through the register view, for opcodes that read it
    always_comb begin
        if (rtUsed) begin
            rtIdx = instr.r.rt;
        end else begin
            // Bits 7:5 name a destination or an immediate here
            rtIdx = '0;
        end
    end

    // Base register plus immediate
    assign memAddr = reg1Data + imm;

    // Record entering the ID slot, a bubble when the slot is squashed
    assign entryRd        = rd;
    assign entryRegWrite  = regWrite & ~nop;
    assign entryMemEnable = memEnable & ~nop;
    assign entryMemAddr   = memAddr;

endmodule

/* stageSlot.sv */
`timescale 1ns/1ps

module stageSlot (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [hazPkg::RegBits-1:0]      inRd,
    input  logic                            inRegWrite,
    input  logic                            inMemEnable,
    input  logic [hazPkg::WordBits-1:0]     inMemAddr,
    input  logic [hazPkg::RegBits-1:0]      rsIdx,
    input  logic [hazPkg::RegBits-1:0]      rtIdx,
    input  logic [hazPkg::WordBits-1:0]     memAddr,
    output logic [hazPkg::RegBits-1:0]      outRd,
    output logic                            outRegWrite,
    output logic                            outMemEnable,
    output logic [hazPkg::WordBits-1:0]     outMemAddr,
    output logic                            rsMatch,
    output logic                            rtMatch,
    output logic                            isLoad,
    output logic                            addrMatch
);

    // Valid bits of the stage record, empty after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outRegWrite  <= 1'b0;
            outMemEnable <= 1'b0;
        end else begin
            outRegWrite  <= inRegWrite;
            outMemEnable <= inMemEnable;
        end
    end

    // Destination and address of the stage record
    always_ff @(posedge clk) begin
        outRd      <= inRd;
        outMemAddr <= inMemAddr;
    end

    // Register compares against the instruction at fetch
    assign rsMatch = outRegWrite && (outRd == rsIdx);
    assign rtMatch = outRegWrite && (outRd == rtIdx);

    // A write that also touches memory is a load
    assign isLoad = outRegWrite && outMemEnable;

    // Enable and address of this same stage
    assign addrMatch = outMemEnable && (outMemAddr == memAddr);

endmodule

/* hazardResolve.sv */
`timescale 1ns/1ps

module hazardResolve (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [hazPkg::NumStages-1:0]    rsMatch,
    input  logic [hazPkg::NumStages-1:0]    rtMatch,
    input  logic [hazPkg::NumStages-1:0]    isLoad,
    input  logic [hazPkg::NumStages-1:0]    addrMatch,
    input  logic                            rsUsed,
    input  logic                            rtUsed,
    input  logic                            isJr,
    input  logic                            isJumpBranch,
    input  logic                            isNop,
    input  logic                            memEnable,
    output logic                            nop,
    output logic                            pcStall,
    output logic [hazPkg::FwdWidth-1:0]     forwards
);
    import hazPkg::*;

    // Source read in EX, result packed as {exToEx, memToEx, hazard}
    function automatic logic [2:0] exPath(
        input logic [NumStages-1:0] match,
        input logic [NumStages-1:0] load,
        input logic                 used
    );
        logic [2:0] res;
        res[2] = used & match[SlotId] & ~load[SlotId];
        res[1] = used & match[SlotEx];
        // Load still in ID, or result not yet reachable through a forward
        res[0] = used & ((match[SlotId] & load[SlotId]) | match[SlotMem] | match[SlotWb]);
        return res;
    endfunction

    logic [2:0] rsPath;
    logic [2:0] rtPath;
    logic       rsJr;
    logic       exToIdRs;
    logic       memToIdRs;
    logic       jrHazard;
    logic       regHazard;
    logic       memHazard;
    logic       anyHazard;
    logic       squashPrev;

    assign rsPath = exPath(rsMatch, isLoad, rsUsed & ~isJr);
    assign rtPath = exPath(rtMatch, isLoad, rtUsed);

    // jr reads Rs in ID, so every path shifts one stage later
    assign rsJr      = rsUsed & isJr;
    assign exToIdRs  = rsJr & rsMatch[SlotEx] & ~isLoad[SlotEx];
    assign memToIdRs = rsJr & rsMatch[SlotMem];
    assign jrHazard  = rsJr & (rsMatch[SlotId]
                             | (rsMatch[SlotEx] & isLoad[SlotEx])
                             | rsMatch[SlotWb]);

    assign regHazard = rsPath[0] | rtPath[0] | jrHazard;

    // Same address still in flight in any stage
    assign memHazard = memEnable & (|addrMatch);
    assign anyHazard = regHazard | memHazard;

    // A nop at fetch never stalls and never needs a bubble
    assign pcStall = anyHazard & ~isNop;
    assign nop     = (anyHazard | squashPrev) & ~isNop;

    assign forwards = {rsPath[2:1], rtPath[2:1], exToIdRs, memToIdRs};

    // Squash the slot after a jump or branch that leaves fetch this cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            squashPrev <= 1'b0;
        end else begin
            squashPrev <= isJumpBranch & ~anyHazard;
        end
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  logic                            clk,
    input  logic                            arstN,
    input  hazPkg::instrWord                instr,
    input  logic [hazPkg::RegBits-1:0]      rd,
    input  logic                            regWrite,
    input  logic                            memEnable,
    input  logic [hazPkg::WordBits-1:0]     reg1Data,
    input  logic [hazPkg::WordBits-1:0]     imm,
    output logic                            nop,
    output logic                            pcStall,
    output logic [hazPkg::FwdWidth-1:0]     forwards
);
    import hazPkg::*;

    // Decoded view of the instruction at fetch
    logic [RegBits-1:0]  rsIdx;
    logic [RegBits-1:0]  rtIdx;
    logic                rsUsed;
    logic                rtUsed;
    logic                isJr;
    logic                isJumpBranch;
    logic                isNop;
    logic [WordBits-1:0] memAddr;

    // Record chain, entry 0 is the record entering ID
    logic [RegBits-1:0]  chainRd       [NumStages+1];
    logic                chainRegWrite [NumStages+1];
    logic                chainMemEnable[NumStages+1];
    logic [WordBits-1:0] chainMemAddr  [NumStages+1];

    // Per-slot compare results
    logic [NumStages-1:0] rsMatch;
    logic [NumStages-1:0] rtMatch;
    logic [NumStages-1:0] isLoad;
    logic [NumStages-1:0] addrMatch;

    instrDecode uDecode (
        .instr          (instr),
        .rd             (rd),
        .regWrite       (regWrite),
        .memEnable      (memEnable),
        .reg1Data       (reg1Data),
        .imm            (imm),
        .nop            (nop),
        .rsIdx          (rsIdx),
        .rtIdx          (rtIdx),
        .rsUsed         (rsUsed),
        .rtUsed         (rtUsed),
        .isJr           (isJr),
        .isJumpBranch   (isJumpBranch),
        .isNop          (isNop),
        .memAddr        (memAddr),
        .entryRd        (chainRd[0]),
        .entryRegWrite  (chainRegWrite[0]),
        .entryMemEnable (chainMemEnable[0]),
        .entryMemAddr   (chainMemAddr[0])
    );

    // ID, EX, MEM, WB in order
    for (genvar k = 0; k < NumStages; k++) begin : gSlot
        stageSlot uSlot (
            .clk          (clk),
            .arstN        (arstN),
            .inRd         (chainRd[k]),
            .inRegWrite   (chainRegWrite[k]),
            .inMemEnable  (chainMemEnable[k]),
            .inMemAddr    (chainMemAddr[k]),
            .rsIdx        (rsIdx),
            .rtIdx        (rtIdx),
            .memAddr      (memAddr),
            .outRd        (chainRd[k+1]),
            .outRegWrite  (chainRegWrite[k+1]),
            .outMemEnable (chainMemEnable[k+1]),
            .outMemAddr   (chainMemAddr[k+1]),
            .rsMatch      (rsMatch[k]),
            .rtMatch      (rtMatch[k]),
            .isLoad       (isLoad[k]),
            .addrMatch    (addrMatch[k])
        );
    end

    hazardResolve uResolve (
        .clk          (clk),
        .arstN        (arstN),
        .rsMatch      (rsMatch),
        .rtMatch      (rtMatch),
        .isLoad       (isLoad),
        .addrMatch    (addrMatch),
        .rsUsed       (rsUsed),
        .rtUsed       (rtUsed),
        .isJr         (isJr),
        .isJumpBranch (isJumpBranch),
        .isNop        (isNop),
        .memEnable    (memEnable),
        .nop          (nop),
        .pcStall      (pcStall),
        .forwards     (forwards)
    );

endmodule

/* hazardUnit_props.sv */
`timescale 1ns/1ps

module hazardUnit_props (
    input logic                            clk,
    input logic                            arstN,
    input hazPkg::instrWord                instr,
    input logic                            nop,
    input logic                            pcStall,
    input logic [hazPkg::FwdWidth-1:0]     forwards
);
    import hazPkg::*;

    // A held fetch always leaves a bubble behind it
    stallMakesBubble: assert property (
        @(posedge clk) disable iff (!arstN)
        pcStall |-> nop
    ) else $error("pcStall high while nop is low");

    // Slots are empty in reset so nothing can stall or squash
    quietInReset: assert property (
        @(posedge clk)
        !arstN |-> (!nop && !pcStall)
    ) else $error("nop or pcStall high during reset");

    // Only jr reads its source in ID
    idForwardOnlyJr: assert property (
        @(posedge clk) disable iff (!arstN)
        (forwards[1:0] != 2'b00) |-> (instr.r.opcode == OpJr)
    ) else $error("forward into ID for an opcode other than jr");

endmodule

/* tb_hazardUnit.sv */
`timescale 1ns/1ps

module tb_hazardUnit;
    import hazPkg::*;

    localparam int NumRandom   = 400;
    localparam int NumDirected = 82;
    // Each instruction is presented once and stalls at most four cycles
    localparam int CycleLimit  = (NumDirected + NumRandom) * 5 + 100;

    // Opcodes of the wider ISA used only as stimulus
    localparam logic [OpBits-1:0] OpLoad = 5'b10001;
    localparam logic [OpBits-1:0] OpAddI = 5'b01000;
    localparam logic [OpBits-1:0] OpBeqz = 5'b01100;

    logic                clk;
    logic                arstN;
    instrWord            instr;
    logic [RegBits-1:0]  rd;
    logic                regWrite;
    logic                memEnable;
    logic [WordBits-1:0] reg1Data;
    logic [WordBits-1:0] imm;
    logic                nop;
    logic                pcStall;
    logic [FwdWidth-1:0] forwards;

    // Expected ID, EX, MEM and WB records
    logic [RegBits-1:0]  mRd   [NumStages];
    logic                mWrite[NumStages];
    logic                mMem  [NumStages];
    logic [WordBits-1:0] mAddr [NumStages];
    logic                mSquash;

    logic [31:0]         lfsrState;
    int                  errors = 0;
    int                  cycles = 0;
    logic                stallSeen;
    logic                nopSeen;
    logic [FwdWidth-1:0] fwdSeen;
    int                  lastStalls;
    logic                lastFirstNop;
    logic [FwdWidth-1:0] lastFwd;
    event                checked;

    hazardUnit uut (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .reg1Data  (reg1Data),
        .imm       (imm),
        .nop       (nop),
        .pcStall   (pcStall),
        .forwards  (forwards)
    );

    bind hazardUnit hazardUnit_props uProps (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (instr),
        .nop      (nop),
        .pcStall  (pcStall),
        .forwards (forwards)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            failRun();
        end
    end

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h at cycle %0d", name, exp, act, cycles);
            errors++;
            failRun();
        end
    endtask

    task automatic checkFwd(input string name, input logic [FwdWidth-1:0] exp,
                            input logic [FwdWidth-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h at cycle %0d", name, exp, act, cycles);
            errors++;
            failRun();
        end
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] drawBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val       = {val[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return val;
    endfunction

    function automatic instrWord makeR(input logic [OpBits-1:0] op, input logic [RegBits-1:0] rs,
                                       input logic [RegBits-1:0] rt,
                                       input logic [FieldBits-1:0] funct);
        instrWord w;
        w.r.opcode = op;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic instrWord makeI(input logic [OpBits-1:0] op, input logic [RegBits-1:0] rs,
                                       input logic [RegBits-1:0] dst,
                                       input logic [FieldBits-1:0] imm5);
        instrWord w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rd     = dst;
        w.i.imm5   = imm5;
        return w;
    endfunction

    // Expected {squashNext, nop, pcStall, forwards} for the word at fetch
    function automatic logic [FwdWidth+2:0] refOutputs(input instrWord w, input logic me,
                                                      input logic [WordBits-1:0] addr);
        logic [OpBits-1:0]    op;
        logic                 readsRs;
        logic                 readsRt;
        logic                 srcRs;
        logic                 jrRs;
        logic                 flow;
        logic                 bubbleOp;
        logic [NumStages-1:0] hitRs;
        logic [NumStages-1:0] hitRt;
        logic [NumStages-1:0] load;
        logic [NumStages-1:0] hitAddr;
        logic                 regHaz;
        logic                 memHaz;
        op       = w.r.opcode;
        bubbleOp = (op == OpNop);
        flow     = (op[OpBits-1 -: ClassBits] == JumpClass)
                || (op[OpBits-1 -: ClassBits] == BranchClass);
        readsRs  = !((op == OpNop) || (op == OpHalt) || (op == OpJ) || (op == OpJal));
        readsRt  = (op == OpAddR) || (op == OpLogicR) || (op == OpStore) || (op == OpStoreUpd);
        srcRs    = readsRs && (op != OpJr);
        jrRs     = readsRs && (op == OpJr);
        for (int k = 0; k < NumStages; k++) begin
            hitRs[k]   = mWrite[k] && (mRd[k] == w.r.rs);
            hitRt[k]   = mWrite[k] && (mRd[k] == w.r.rt);
            load[k]    = mWrite[k] && mMem[k];
            hitAddr[k] = mMem[k] && (mAddr[k] == addr);
        end
        // Sources read in EX wait for a load in ID or a writer past EX
        regHaz = (srcRs && ((hitRs[0] && load[0]) || hitRs[2] || hitRs[3]))
              || (readsRt && ((hitRt[0] && load[0]) || hitRt[2] || hitRt[3]))
              || (jrRs && (hitRs[0] || (hitRs[1] && load[1]) || hitRs[3]));
        memHaz = me && (hitAddr != '0);
        return {flow && !(regHaz || memHaz),
                (regHaz || memHaz || mSquash) && !bubbleOp,
                (regHaz || memHaz) && !bubbleOp,
                srcRs && hitRs[0] && !load[0],
                srcRs && hitRs[1],
                readsRt && hitRt[0] && !load[0],
                readsRt && hitRt[1],
                jrRs && hitRs[1] && !load[1],
                jrRs && hitRs[2]};
    endfunction

    // Shift the records as the coming edge will
    task automatic advanceModel(input logic expNop, input logic squashNext);
        for (int k = NumStages - 1; k > 0; k--) begin
            mRd[k]    = mRd[k-1];
            mWrite[k] = mWrite[k-1];
            mMem[k]   = mMem[k-1];
            mAddr[k]  = mAddr[k-1];
        end
        mRd[0]    = rd;
        mWrite[0] = regWrite && !expNop;
        mMem[0]   = memEnable && !expNop;
        mAddr[0]  = reg1Data + imm;
        mSquash   = squashNext;
    endtask

    // Compare one time unit before every rising edge
    initial begin : compareLoop
        logic [FwdWidth+2:0] exp;
        for (int k = 0; k < NumStages; k++) begin
            mRd[k]    = '0;
            mWrite[k] = 1'b0;
            mMem[k]   = 1'b0;
            mAddr[k]  = '0;
        end
        mSquash = 1'b0;
        forever begin
            @(negedge clk);
            #1;
            exp = refOutputs(instr, memEnable, reg1Data + imm);
            checkFlag("nop", exp[FwdWidth+1], nop);
            checkFlag("pcStall", exp[FwdWidth], pcStall);
            checkFwd("forwards", exp[FwdWidth-1:0], forwards);
            stallSeen = pcStall;
            nopSeen   = nop;
            fwdSeen   = forwards;
            if (arstN) begin
                advanceModel(exp[FwdWidth+1], exp[FwdWidth+2]);
            end
            -> checked;
        end
    end

    task automatic present(input instrWord w, input logic [RegBits-1:0] dst, input logic wr,
                           input logic me, input logic [WordBits-1:0] base,
                           input logic [WordBits-1:0] off);
        @(posedge clk);
        instr     <= w;
        rd        <= dst;
        regWrite  <= wr;
        memEnable <= me;
        reg1Data  <= base;
        imm       <= off;
        @(checked);
        lastFirstNop = nopSeen;
        lastStalls   = 0;
        // Same word stays at fetch until the stall clears
        while (stallSeen) begin
            lastStalls++;
            @(checked);
        end
        lastFwd = fwdSeen;
    endtask

    task automatic aluOp(input logic [2:0] dst, input logic [2:0] rs, input logic [2:0] rt);
        present(makeR(OpAddR, rs, rt, {2'b00, dst}), dst, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic loadWord(input logic [2:0] dst, input logic [2:0] rs,
                            input logic [WordBits-1:0] addr);
        present(makeI(OpLoad, rs, dst, 5'd0), dst, 1'b1, 1'b1, addr, '0);
    endtask

    task automatic storeWord(input logic [2:0] rs, input logic [2:0] rt,
                             input logic [WordBits-1:0] addr);
        present(makeR(OpStore, rs, rt, 5'd0), 3'd0, 1'b0, 1'b1, addr, '0);
    endtask

    task automatic jumpReg(input logic [2:0] rs);
        present(makeI(OpJr, rs, 3'd0, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic bubbleInstr();
        present(makeI(OpNop, 3'd0, 3'd0, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic flushPipe();
        repeat (NumStages) bubbleInstr();
    endtask

    task automatic aluChainTest();
        aluOp(3'd1, 3'd2, 3'd3);
        aluOp(3'd4, 3'd5, 3'd6);
        aluOp(3'd2, 3'd4, 3'd1);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        checkFwd("forwards", 6'b100100, lastFwd);
        aluOp(3'd3, 3'd4, 3'd2);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        checkFwd("forwards", 6'b011000, lastFwd);
        flushPipe();
    endtask

    task automatic loadUseTest();
        loadWord(3'd3, 3'd0, 16'h0200);
        aluOp(3'd1, 3'd3, 3'd0);
        checkFlag("pcStall", 1'b1, lastStalls == 1);
        checkFwd("forwards", 6'b010000, lastFwd);
        flushPipe();
    endtask

    task automatic jrTest();
        aluOp(3'd6, 3'd1, 3'd2);
        jumpReg(3'd6);
        checkFlag("pcStall", 1'b1, lastStalls == 1);
        checkFwd("forwards", 6'b000010, lastFwd);
        flushPipe();
        aluOp(3'd6, 3'd1, 3'd2);
        bubbleInstr();
        jumpReg(3'd6);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        checkFwd("forwards", 6'b000010, lastFwd);
        flushPipe();
        aluOp(3'd6, 3'd1, 3'd2);
        bubbleInstr();
        bubbleInstr();
        jumpReg(3'd6);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        checkFwd("forwards", 6'b000001, lastFwd);
        flushPipe();
        // Load two ahead of the jr cannot reach ID in time
        loadWord(3'd6, 3'd0, 16'h0210);
        bubbleInstr();
        jumpReg(3'd6);
        checkFlag("pcStall", 1'b1, lastStalls == 1);
        checkFwd("forwards", 6'b000001, lastFwd);
        flushPipe();
    endtask

    task automatic memTest();
        storeWord(3'd1, 3'd2, 16'h0300);
        loadWord(3'd4, 3'd0, 16'h0300);
        checkFlag("pcStall", 1'b1, lastStalls == NumStages);
        flushPipe();
        storeWord(3'd1, 3'd2, 16'h0300);
        loadWord(3'd4, 3'd0, 16'h0308);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        flushPipe();
        // Bits 7:5 of an immediate word equal a pending destination
        loadWord(3'd5, 3'd0, 16'h0310);
        present(makeI(OpAddI, 3'd1, 3'd5, 5'd3), 3'd5, 1'b1, 1'b0, '0, '0);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        checkFwd("forwards", 6'b000000, lastFwd);
        flushPipe();
    endtask

    task automatic jumpTest();
        present(makeI(OpJ, 3'd0, 3'd0, 5'd9), 3'd0, 1'b0, 1'b0, '0, '0);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        aluOp(3'd1, 3'd2, 3'd3);
        checkFlag("nop", 1'b1, lastFirstNop);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        flushPipe();
        present(makeI(OpJ, 3'd0, 3'd0, 5'd9), 3'd0, 1'b0, 1'b0, '0, '0);
        bubbleInstr();
        checkFlag("nop", 1'b0, lastFirstNop);
        flushPipe();
        storeWord(3'd1, 3'd2, 16'h0320);
        present(makeI(OpNop, 3'd0, 3'd0, 5'd0), 3'd0, 1'b0, 1'b1, 16'h0320, '0);
        checkFlag("nop", 1'b0, lastFirstNop);
        checkFlag("pcStall", 1'b0, lastStalls != 0);
        flushPipe();
    endtask

    // Weighted toward ALU ops and memory accesses
    function automatic logic [OpBits-1:0] pickOpcode(input logic [3:0] idx);
        case (idx)
            4'd0, 4'd1, 4'd2: return OpAddR;
            4'd3, 4'd4:       return OpLogicR;
            4'd5, 4'd6, 4'd7: return OpLoad;
            4'd8, 4'd9:       return OpStore;
            4'd10:            return OpStoreUpd;
            4'd11:            return OpAddI;
            4'd12:            return OpNop;
            4'd13:            return OpBeqz;
            4'd14:            return OpJr;
            default:          return OpJal;
        endcase
    endfunction

    task automatic randomInstr();
        instrWord            w;
        logic [OpBits-1:0]   op;
        logic [RegBits-1:0]  dst;
        logic                wr;
        logic                me;
        logic [WordBits-1:0] base;
        logic [WordBits-1:0] off;
        op         = pickOpcode(4'(drawBits(4)));
        w.r.opcode = op;
        w.r.rs     = 3'(drawBits(3));
        w.r.rt     = 3'(drawBits(3));
        w.r.funct  = 5'(drawBits(5));
        wr = (op == OpAddR) || (op == OpLogicR) || (op == OpLoad) || (op == OpStoreUpd)
          || (op == OpAddI) || (op == OpJal);
        me = (op == OpLoad) || (op == OpStore) || (op == OpStoreUpd);
        if ((op == OpAddR) || (op == OpLogicR)) begin
            dst = w.r.funct[2:0];
        end else if (op == OpStoreUpd) begin
            dst = w.r.rs;
        end else if (op == OpJal) begin
            dst = 3'd7;
        end else begin
            dst = w.i.rd;
        end
        // Small address pool so accesses collide
        base = 16'h0100 + {12'd0, 2'(drawBits(2)), 2'b00};
        off  = {14'd0, 2'(drawBits(2))};
        present(w, dst, wr, me, base, off);
    endtask

    initial begin
        clk       = 1'b0;
        arstN     = 1'b0;
        instr     = makeI(OpNop, 3'd0, 3'd0, 5'd0);
        rd        = '0;
        regWrite  = 1'b0;
        memEnable = 1'b0;
        reg1Data  = '0;
        imm       = '0;
        lfsrState = 32'h9a88_e3a5;
        @(posedge clk);
        // A store reading rs, rt and memory while the slots sit in reset
        instr     <= makeR(OpStore, 3'd1, 3'd2, 5'd0);
        memEnable <= 1'b1;
        reg1Data  <= 16'h0100;
        repeat (15) @(posedge clk);
        arstN     <= 1'b1;
        instr     <= makeI(OpNop, 3'd0, 3'd0, 5'd0);
        memEnable <= 1'b0;
        reg1Data  <= '0;
        aluChainTest();
        loadUseTest();
        jrTest();
        memTest();
        jumpTest();
        repeat (NumRandom) randomInstr();
        flushPipe();
        if (errors == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            failRun();
        end
    end

endmodule

/* tb.f */
hazPkg.sv
instrDecode.sv
stageSlot.sv
hazardResolve.sv
hazardUnit.sv
hazardUnit_props.sv
tb_hazardUnit.sv

/* Bender.yml */
package:
  name: hazard_unit

sources:
  - files:
      - hazPkg.sv
      - instrDecode.sv
      - stageSlot.sv
      - hazardResolve.sv
      - hazardUnit.sv
  - target: test
    files:
      - hazardUnit_props.sv
      - tb_hazardUnit.sv
